//--- mc_bus_pkg.sv
/*
 * shared bus fabric definitions
 * bus widths and the master request struct
 * device index and bus owner enums
 * i/o page map of the board
 */

`default_nettype none

package mc_bus_pkg;

   //********************
   // bus widths
   //********************
   typedef logic [16:0] wb_addr_t;    // bus address, bit 16 set in console mode
   typedef logic [15:0] wb_data_t;    // one data word
   typedef logic [1:0]  wb_sel_t;     // byte select, bit 1 is the high byte

   localparam wb_sel_t SEL_WORD = 2'b11;   // both bytes

   // request of one bus master
   typedef struct packed {
      logic     cyc;      // bus cycle, also the dma bus request
      logic     stb;      // data strobe
      logic     we;       // 1 for write
      wb_sel_t  sel;
      wb_addr_t adr;
      wb_data_t dat;      // write data
   } wb_req_t;

   //********************
   // devices
   //********************
   typedef enum logic [3:0] {
      DEV_ROM   = 4'd0,   // shadow monitor rom
      DEV_DRAM  = 4'd1,   // main memory
      DEV_UART1 = 4'd2,   // console port
      DEV_UART2 = 4'd3,
      DEV_LPT   = 4'd4,   // printer port
      DEV_RK    = 4'd5,
      DEV_DW    = 4'd6,
      DEV_RX    = 4'd7,
      DEV_MY    = 4'd8,
      DEV_KGD   = 4'd9    // graphics
   } dev_e;

   localparam int N_DEV = 10;

   typedef logic [N_DEV-1:0]     dev_vec_t;   // one bit per dev_e
   typedef wb_data_t [N_DEV-1:0] dev_dat_t;   // one read word per dev_e

   // who drives the shared bus
   typedef enum logic [1:0] {
      OWN_CPU = 2'd0,
      OWN_RK  = 2'd1,     // rk disk dma
      OWN_MY  = 2'd2      // my disk dma
   } bus_owner_e;

   //********************
   // i/o page map
   //********************
   // base in octal, plus number of low address bits that stay free
   localparam wb_addr_t    UART1_BASE = 17'o177560;   // 177560..177566
   localparam int unsigned UART1_IGN  = 3;
   localparam wb_addr_t    UART2_BASE = 17'o176500;   // 176500..176506
   localparam int unsigned UART2_IGN  = 3;
   localparam wb_addr_t    LPT_BASE   = 17'o177514;   // 177514..177516
   localparam int unsigned LPT_IGN    = 2;
   localparam wb_addr_t    RK_BASE    = 17'o177400;   // 177400..177416
   localparam int unsigned RK_IGN     = 4;
   localparam wb_addr_t    DW_BASE    = 17'o174000;   // 174000..174036
   localparam int unsigned DW_IGN     = 5;
   localparam wb_addr_t    RX_BASE    = 17'o177170;   // 177170..177172
   localparam int unsigned RX_IGN     = 2;
   localparam wb_addr_t    MY_BASE    = 17'o172140;   // 172140..172142
   localparam int unsigned MY_IGN     = 2;
   localparam wb_addr_t    KGD_BASE   = 17'o176640;   // 176640..176646
   localparam int unsigned KGD_IGN    = 3;

   localparam logic [3:0] ROM_TAG     = 4'b1110;   // adr[16:13], console 140000..157776
   localparam logic [2:0] IO_PAGE_TAG = 3'b111;    // adr[15:13] of the top 8k

endpackage

`default_nettype wire

//--- bus_master_arbiter.sv
/*
 * bus ownership between the cpu and the rk / my dma masters
 * registered owner with fixed priority, switched only while the bus is idle
 * request mux onto the shared bus and ack return to the owner
 */

`timescale 1ns/1ps
`default_nettype none

module bus_master_arbiter (
   input  logic                wb_clk,
   input  logic                arst_n_i,
   input  mc_bus_pkg::wb_req_t cpu_req_i,     // processor master
   input  mc_bus_pkg::wb_req_t rk_dma_i,      // rk dma, cyc is the bus request
   input  mc_bus_pkg::wb_req_t my_dma_i,      // my dma, cyc is the bus request
   input  logic                bus_ack_i,     // merged device ack
   output mc_bus_pkg::wb_req_t bus_req_o,     // shared bus to all devices
   output logic                cpu_gnt_o,
   output logic                rk_dma_gnt_o,
   output logic                my_dma_gnt_o,
   output logic                cpu_ack_o,
   output logic                rk_dma_ack_o,
   output logic                my_dma_ack_o
);

   import mc_bus_pkg::*;

   bus_owner_e owner_q;    // current bus owner
   bus_owner_e owner_d;    // owner taken at the next idle edge

   //********************
   // priority rule
   //********************
   // rk before my, cpu gets the bus back when no dma asks
   always_comb begin
      if (rk_dma_i.cyc) begin
         owner_d = OWN_RK;
      end else if (my_dma_i.cyc) begin
         owner_d = OWN_MY;
      end else begin
         owner_d = OWN_CPU;
      end
   end

   always_ff @(posedge wb_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         owner_q <= OWN_CPU;
      end else if (!bus_req_o.cyc) begin
         owner_q <= owner_d;   // switch only between bus cycles
      end
   end

   //********************
   // request mux
   //********************
   always_comb begin
      case (owner_q)
         OWN_RK: begin
            bus_req_o     = rk_dma_i;
            bus_req_o.sel = SEL_WORD;   // dma moves whole words
         end
         OWN_MY: begin
            bus_req_o     = my_dma_i;
            bus_req_o.sel = SEL_WORD;
         end
         default: begin
            bus_req_o = cpu_req_i;
         end
      endcase
   end

   // grants straight from the owner register
   assign cpu_gnt_o    = (owner_q == OWN_CPU);
   assign rk_dma_gnt_o = (owner_q == OWN_RK);
   assign my_dma_gnt_o = (owner_q == OWN_MY);

   // ack goes to the owner only, the others keep waiting
   assign cpu_ack_o    = bus_ack_i & cpu_gnt_o;
   assign rk_dma_ack_o = bus_ack_i & rk_dma_gnt_o;
   assign my_dma_ack_o = bus_ack_i & my_dma_gnt_o;

   // a dma cycle stays on the bus with its owner until the ack
   // cpu ends unanswered cycles by its own bus timeout
   a_owner_stable : assert property (
      @(posedge wb_clk) disable iff (!arst_n_i)
      bus_req_o.cyc && !bus_ack_i && (owner_q != OWN_CPU)
         |=> bus_req_o.cyc && $stable(owner_q)
   ) else $error("dma cycle left the bus before its ack");

endmodule

`default_nettype wire

//--- io_page_decoder.sv
/*
 * address decode of the shared bus
 * shadow rom, dram in user and console mode, i/o page registers
 * one-hot device strobes, combinational
 */

`timescale 1ns/1ps
`default_nettype none

module io_page_decoder (
   input  mc_bus_pkg::wb_addr_t bus_adr_i,    // shared bus address
   input  logic                 bus_cyc_i,
   input  logic                 bus_stb_i,
   output mc_bus_pkg::dev_vec_t dev_stb_o     // one-hot or idle
);

   import mc_bus_pkg::*;

   dev_vec_t hit;   // address match before the strobe gate

   // register window, the low ign bits select inside it
   function automatic logic in_io_window(input wb_addr_t adr, input wb_addr_t base,
                                         input int unsigned ign);
      wb_addr_t mask;
      mask = ~((wb_addr_t'(1) << ign) - wb_addr_t'(1));   // fixed bits only
      return (adr & mask) == (base & mask);
   endfunction

   //********************
   // memory regions
   //********************
   always_comb begin
      hit            = '0;
      hit[DEV_ROM]   = (bus_adr_i[16:13] == ROM_TAG);
      // user mode: all but the i/o page, console mode: only the top 8k
      hit[DEV_DRAM]  = (bus_adr_i[15:13] != IO_PAGE_TAG) ^ bus_adr_i[16];
      // i/o page registers
      hit[DEV_UART1] = in_io_window(bus_adr_i, UART1_BASE, UART1_IGN);
      hit[DEV_UART2] = in_io_window(bus_adr_i, UART2_BASE, UART2_IGN);
      hit[DEV_LPT]   = in_io_window(bus_adr_i, LPT_BASE, LPT_IGN);
      hit[DEV_RK]    = in_io_window(bus_adr_i, RK_BASE, RK_IGN);
      hit[DEV_DW]    = in_io_window(bus_adr_i, DW_BASE, DW_IGN);
      hit[DEV_RX]    = in_io_window(bus_adr_i, RX_BASE, RX_IGN);
      hit[DEV_MY]    = in_io_window(bus_adr_i, MY_BASE, MY_IGN);
      hit[DEV_KGD]   = in_io_window(bus_adr_i, KGD_BASE, KGD_IGN);
   end

   assign dev_stb_o = (bus_cyc_i && bus_stb_i) ? hit : '0;   // strobe needs cyc and stb

   // overlapping windows in the map would drive two devices at once
   always_comb begin
      a_one_strobe : assert ($onehot0(dev_stb_o))
         else $error("more than one device strobe");
   end

endmodule

`default_nettype wire

//--- bus_response_merge.sv
/*
 * response path of the shared bus
 * or of all device acks
 * read data mux built from the strobed devices
 */

`timescale 1ns/1ps
`default_nettype none

module bus_response_merge (
   input  mc_bus_pkg::dev_vec_t dev_stb_i,    // from the decoder
   input  mc_bus_pkg::dev_vec_t dev_ack_i,    // one ack per device
   input  mc_bus_pkg::dev_dat_t dev_dat_i,    // one read word per device
   output logic                 bus_ack_o,
   output mc_bus_pkg::wb_data_t rd_dat_o      // shared by all masters
);

   import mc_bus_pkg::*;

   //********************
   // ack
   //********************
   // a device acks only while strobed, so a plain or is enough
   assign bus_ack_o = |dev_ack_i;

   //********************
   // read data
   //********************
   // unselected devices count as zero
   always_comb begin
      rd_dat_o = '0;
      for (int i = 0; i < N_DEV; i++) begin
         if (dev_stb_i[i]) begin
            rd_dat_o = rd_dat_o | dev_dat_i[i];
         end
      end
   end

endmodule

`default_nettype wire

//--- sd_card_arbiter.sv
/*
 * sd card sharing between the disk controllers
 * fixed priority grant, held until the client drops its request
 * mosi and cs routing to the card
 */

`timescale 1ns/1ps
`default_nettype none

module sd_card_arbiter #(
   parameter int N_SD_CLIENTS = 4
) (
   input  logic                    wb_clk,
   input  logic                    arst_n_i,
   input  logic [N_SD_CLIENTS-1:0] sd_req_i,      // card request per client
   input  logic [N_SD_CLIENTS-1:0] sd_mosi_i,
   input  logic [N_SD_CLIENTS-1:0] sd_cs_i,
   output logic [N_SD_CLIENTS-1:0] sd_gnt_o,      // card granted
   output logic                    sdcard_mosi_o,
   output logic                    sdcard_cs_o
);

   localparam int SEL_W = (N_SD_CLIENTS > 1) ? $clog2(N_SD_CLIENTS) : 1;

   typedef logic [N_SD_CLIENTS-1:0] sd_vec_t;   // one bit per client
   typedef logic [SEL_W-1:0]        sd_sel_t;   // client index

   sd_vec_t gnt_q;       // active grant, one-hot or idle
   sd_vec_t first_req;   // lowest requesting client
   sd_sel_t sel;         // client routed to the card

   // isolate lowest set bit, index 0 wins
   assign first_req = sd_req_i & (~sd_req_i + sd_vec_t'(1));

   //********************
   // grant register
   //********************
   always_ff @(posedge wb_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         gnt_q <= '0;
      end else if (gnt_q == '0) begin
         gnt_q <= first_req;              // idle, look for a requester
      end else if ((gnt_q & sd_req_i) == '0) begin
         gnt_q <= '0;                     // owner let go of the card
      end
   end

   assign sd_gnt_o = gnt_q;

   //********************
   // line routing
   //********************
   always_comb begin
      sel = '0;                           // client 0 when idle
      for (int k = 0; k < N_SD_CLIENTS; k++) begin
         if (gnt_q[k]) begin
            sel = sd_sel_t'(k);
         end
      end
   end

   assign sdcard_mosi_o = sd_mosi_i[sel];
   assign sdcard_cs_o   = sd_cs_i[sel];

   // two controllers on the card at once would corrupt the spi exchange
   a_one_grant : assert property (
      @(posedge wb_clk) disable iff (!arst_n_i)
      $onehot0(gnt_q)
   ) else $error("more than one sd card grant");

endmodule

`default_nettype wire

//--- mc_bus_fabric.sv
/*
 * shared bus fabric of the board
 * master arbiter, address decoder, response merge, sd card arbiter
 */

`timescale 1ns/1ps
`default_nettype none

module mc_bus_fabric #(
   parameter int N_SD_CLIENTS = 4
) (
   input  logic                    wb_clk,
   input  logic                    arst_n_i,
   // masters
   input  mc_bus_pkg::wb_req_t     cpu_req_i,
   input  mc_bus_pkg::wb_req_t     rk_dma_i,
   input  mc_bus_pkg::wb_req_t     my_dma_i,
   output logic                    cpu_gnt_o,
   output logic                    rk_dma_gnt_o,
   output logic                    my_dma_gnt_o,
   output logic                    cpu_ack_o,
   output logic                    rk_dma_ack_o,
   output logic                    my_dma_ack_o,
   output mc_bus_pkg::wb_req_t     bus_req_o,      // to all devices
   output mc_bus_pkg::wb_data_t    rd_dat_o,       // to all masters
   // devices
   output mc_bus_pkg::dev_vec_t    dev_stb_o,
   input  mc_bus_pkg::dev_vec_t    dev_ack_i,
   input  mc_bus_pkg::dev_dat_t    dev_dat_i,
   // sd card clients and the card
   input  logic [N_SD_CLIENTS-1:0] sd_req_i,
   input  logic [N_SD_CLIENTS-1:0] sd_mosi_i,
   input  logic [N_SD_CLIENTS-1:0] sd_cs_i,
   output logic [N_SD_CLIENTS-1:0] sd_gnt_o,
   output logic                    sdcard_mosi_o,
   output logic                    sdcard_cs_o
);

   logic bus_ack;   // merged ack, back to the arbiter

   bus_master_arbiter i_bus_master_arbiter (
      .wb_clk       (wb_clk),
      .arst_n_i     (arst_n_i),
      .cpu_req_i    (cpu_req_i),
      .rk_dma_i     (rk_dma_i),
      .my_dma_i     (my_dma_i),
      .bus_ack_i    (bus_ack),
      .bus_req_o    (bus_req_o),
      .cpu_gnt_o    (cpu_gnt_o),
      .rk_dma_gnt_o (rk_dma_gnt_o),
      .my_dma_gnt_o (my_dma_gnt_o),
      .cpu_ack_o    (cpu_ack_o),
      .rk_dma_ack_o (rk_dma_ack_o),
      .my_dma_ack_o (my_dma_ack_o)
   );

   io_page_decoder i_io_page_decoder (
      .bus_adr_i (bus_req_o.adr),
      .bus_cyc_i (bus_req_o.cyc),
      .bus_stb_i (bus_req_o.stb),
      .dev_stb_o (dev_stb_o)
   );

   bus_response_merge i_bus_response_merge (
      .dev_stb_i (dev_stb_o),     // same strobes the devices see
      .dev_ack_i (dev_ack_i),
      .dev_dat_i (dev_dat_i),
      .bus_ack_o (bus_ack),
      .rd_dat_o  (rd_dat_o)
   );

   sd_card_arbiter #(
      .N_SD_CLIENTS (N_SD_CLIENTS)
   ) i_sd_card_arbiter (
      .wb_clk        (wb_clk),
      .arst_n_i      (arst_n_i),
      .sd_req_i      (sd_req_i),
      .sd_mosi_i     (sd_mosi_i),
      .sd_cs_i       (sd_cs_i),
      .sd_gnt_o      (sd_gnt_o),
      .sdcard_mosi_o (sdcard_mosi_o),
      .sdcard_cs_o   (sdcard_cs_o)
   );

endmodule

`default_nettype wire

//--- tb_mc_bus_fabric.sv
/*
 * testbench of the shared bus fabric
 * clock, reset, device models and cpu / dma / sd client stimulus
 * reference decode and sd grant model, compare process, watchdog
 */

`timescale 1ns/1ps
`default_nettype none

module tb_mc_bus_fabric;

   import mc_bus_pkg::*;

   localparam int     N_SD        = 4;
   localparam int     CLK_NS      = 100;
   localparam int     N_RANDOM    = 300;         // random cpu reads
   localparam int     N_SD_CYCLES = 200;
   localparam int     ACK_LIMIT   = 16;          // cycles a master waits
   localparam int     N_TRANS     = N_RANDOM + 16 + 3 + N_SD_CYCLES;
   localparam longint WATCHDOG_NS = longint'(N_TRANS) * 20 * CLK_NS;
   localparam wb_addr_t IO_BASES [8] = '{UART1_BASE, UART2_BASE, LPT_BASE, RK_BASE,
                                         DW_BASE, RX_BASE, MY_BASE, KGD_BASE};

   typedef logic [N_SD-1:0] sd_vec_t;

   logic     wb_clk = 1'b0;
   logic     arst_n_i = 1'b0;
   wb_req_t  cpu_req = '0, rk_dma = '0, my_dma = '0;
   dev_vec_t dev_ack = '0;                       // device model outputs
   dev_dat_t dev_dat = '0;
   sd_vec_t  sd_req = '0, sd_mosi = '0, sd_cs = '0;
   logic     cpu_gnt, rk_gnt, my_gnt, cpu_ack, rk_ack, my_ack;
   wb_req_t  bus_req;
   wb_data_t rd_dat;
   dev_vec_t dev_stb;
   sd_vec_t  sd_gnt;
   logic     sdcard_mosi, sdcard_cs;

   int unsigned n_checks = 0, n_errors = 0;
   int unsigned dly_q [N_DEV];                   // ack delay per device
   logic        cyc_seen = 1'b0;                 // bus cyc at the last falling edge
   logic [2:0]  gnt_seen = '0;
   sd_vec_t     sd_exp = '0;                     // reference sd grant

   always #(CLK_NS / 2) wb_clk = ~wb_clk;

   mc_bus_fabric #(.N_SD_CLIENTS(N_SD)) i_mc_bus_fabric (
      .wb_clk (wb_clk), .arst_n_i (arst_n_i),
      .cpu_req_i (cpu_req), .rk_dma_i (rk_dma), .my_dma_i (my_dma),
      .cpu_gnt_o (cpu_gnt), .rk_dma_gnt_o (rk_gnt), .my_dma_gnt_o (my_gnt),
      .cpu_ack_o (cpu_ack), .rk_dma_ack_o (rk_ack), .my_dma_ack_o (my_ack),
      .bus_req_o (bus_req), .rd_dat_o (rd_dat),
      .dev_stb_o (dev_stb), .dev_ack_i (dev_ack), .dev_dat_i (dev_dat),
      .sd_req_i (sd_req), .sd_mosi_i (sd_mosi), .sd_cs_i (sd_cs), .sd_gnt_o (sd_gnt),
      .sdcard_mosi_o (sdcard_mosi), .sdcard_cs_o (sdcard_cs)
   );

   //********************
   // reference model
   //********************
   function automatic logic in_window(input wb_addr_t adr, input wb_addr_t base,
                                      input int unsigned ign);
      return (adr >> ign) == (base >> ign);      // low ign bits are free
   endfunction

   function automatic dev_vec_t expected_strobes(input wb_addr_t adr);
      dev_vec_t v;
      v            = '0;
      v[DEV_ROM]   = (adr[16:13] == 4'b1110);
      v[DEV_DRAM]  = ((adr[15:13] != 3'b111) != adr[16]);   // user and console map
      v[DEV_UART1] = in_window(adr, UART1_BASE, UART1_IGN);
      v[DEV_UART2] = in_window(adr, UART2_BASE, UART2_IGN);
      v[DEV_LPT]   = in_window(adr, LPT_BASE, LPT_IGN);
      v[DEV_RK]    = in_window(adr, RK_BASE, RK_IGN);
      v[DEV_DW]    = in_window(adr, DW_BASE, DW_IGN);
      v[DEV_RX]    = in_window(adr, RX_BASE, RX_IGN);
      v[DEV_MY]    = in_window(adr, MY_BASE, MY_IGN);
      v[DEV_KGD]   = in_window(adr, KGD_BASE, KGD_IGN);
      return v;
   endfunction

   function automatic int strobe_index(input dev_vec_t v);
      int idx;
      idx = 0;
      for (int d = 0; d < N_DEV; d++) begin
         if (v[d]) idx = d;
      end
      return idx;
   endfunction

   // word a device model returns, mixes device number and address
   function automatic wb_data_t model_word(input int dev, input wb_addr_t adr);
      return (wb_data_t'(dev) << 12) ^ adr[15:0] ^ 16'h5a3c;
   endfunction

   // grant after the next edge, lowest index wins, held until release
   function automatic sd_vec_t next_sd_grant(input sd_vec_t cur, input sd_vec_t req);
      if (cur != '0) return ((cur & req) == '0) ? '0 : cur;
      for (int k = 0; k < N_SD; k++) begin
         if (req[k]) return sd_vec_t'(1) << k;
      end
      return '0;
   endfunction

   function automatic logic [1:0] expected_sd_lines(input sd_vec_t gnt);
      int idx;
      idx = 0;                                   // client 0 when idle
      for (int k = 0; k < N_SD; k++) begin
         if (gnt[k]) idx = k;
      end
      return {sd_mosi[idx], sd_cs[idx]};
   endfunction

   function automatic logic owner_signal(input bus_owner_e who, input logic want_ack);
      case (who)
         OWN_RK:  return want_ack ? rk_ack : rk_gnt;
         OWN_MY:  return want_ack ? my_ack : my_gnt;
         default: return want_ack ? cpu_ack : cpu_gnt;
      endcase
   endfunction

   task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("[FAIL] %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
      end
   endtask

   //********************
   // device models and compare process
   //********************
   always @(posedge wb_clk) begin
      for (int d = 0; d < N_DEV; d++) begin
         if (!arst_n_i || dev_stb[d] !== 1'b1 || dev_ack[d]) begin
            dev_ack[d] <= 1'b0;                  // single cycle ack
            dly_q[d]   <= $urandom_range(3, 0);
         end else if (dly_q[d] == 0) begin
            dev_ack[d] <= 1'b1;
            dev_dat[d] <= model_word(d, bus_req.adr);
         end else begin
            dly_q[d] <= dly_q[d] - 1;
         end
      end
   end

   // inputs only move on the rising edge, so the falling edge is quiet
   always @(negedge wb_clk) begin
      if (arst_n_i) begin
         if (!(cpu_req.cyc || rk_dma.cyc || my_dma.cyc)) begin
            check_eq(64'(dev_stb), 64'(0), "device strobes on an idle bus");
         end
         if (cyc_seen) check_eq(64'({cpu_gnt, rk_gnt, my_gnt}), 64'(gnt_seen),
                                "owner changed inside a bus cycle");
         check_eq(64'(sd_gnt), 64'(sd_exp), "sd grant");
         check_eq(64'({sdcard_mosi, sdcard_cs}), 64'(expected_sd_lines(sd_exp)), "sd lines");
      end
      cyc_seen = bus_req.cyc;
      gnt_seen = {cpu_gnt, rk_gnt, my_gnt};
      sd_exp   = arst_n_i ? next_sd_grant(sd_exp, sd_req) : '0;
   end

   //********************
   // master tasks
   //********************
   task automatic wait_for(input bus_owner_e who, input logic want_ack, output logic ok);
      ok = 1'b0;
      for (int n = 0; n < ACK_LIMIT && !ok; n++) begin
         @(negedge wb_clk);
         ok = owner_signal(who, want_ack);
      end
   endtask

   task automatic cpu_read(input wb_addr_t adr);
      dev_vec_t exp_stb;
      wb_req_t  req;
      logic     ok;
      exp_stb = expected_strobes(adr);
      req     = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, sel: wb_sel_t'($urandom_range(3, 1)),
                  adr: adr, dat: '0};
      @(posedge wb_clk);
      cpu_req <= req;
      @(negedge wb_clk);                         // no ack can arrive before this edge
      check_eq(64'(bus_req), 64'(req), "cpu request on the bus");
      check_eq(64'(dev_stb), 64'(exp_stb), "device strobes");
      if (exp_stb != '0) begin                   // a hole in the map gets no answer
         wait_for(OWN_CPU, 1'b1, ok);
         if (!ok) begin
            n_errors++;
            $display("no ack for the cpu read of address %0o", adr);
         end else begin
            check_eq(64'(rd_dat), 64'(model_word(strobe_index(exp_stb), adr)), "read data");
            check_eq(64'({rk_ack, my_ack}), 64'(0), "cpu ack seen by a dma master");
         end
      end
      @(posedge wb_clk);
      cpu_req <= '0;
   endtask

   // grant, forwarded fields, ack to the owner only, then release
   task automatic dma_cycle(input bus_owner_e who, input wb_req_t cmd);
      wb_req_t fwd;
      logic    ok;
      fwd     = cmd;
      fwd.sel = 2'b11;                           // dma always moves words
      wait_for(who, 1'b0, ok);
      check_eq(64'(ok), 64'(1), "dma master granted");
      check_eq(64'({cpu_gnt, rk_gnt, my_gnt}), 64'((who == OWN_RK) ? 3'b010 : 3'b001),
               "grants during dma");
      check_eq(64'(bus_req), 64'(fwd), "dma request on the bus");
      check_eq(64'(dev_stb), 64'(expected_strobes(cmd.adr)), "device strobes during dma");
      wait_for(who, 1'b1, ok);
      if (!ok) begin
         n_errors++;
         $display("no ack for the %s dma cycle", who.name());
      end else begin
         check_eq(64'({cpu_ack, rk_ack, my_ack}), 64'((who == OWN_RK) ? 3'b010 : 3'b001),
                  "ack routing during dma");
      end
      @(posedge wb_clk);
      if (who == OWN_RK) rk_dma <= '0;
      else my_dma <= '0;
   endtask

   task automatic dma_test();
      wb_req_t rk_cmd;
      wb_req_t my_cmd;
      logic    ok;
      rk_cmd = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, sel: 2'b01, adr: 17'o001000, dat: 16'o123456};
      my_cmd = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, sel: 2'b10, adr: 17'o002000, dat: '0};
      @(posedge wb_clk);
      rk_dma <= rk_cmd;                          // both ask on an idle bus
      my_dma <= my_cmd;
      dma_cycle(OWN_RK, rk_cmd);
      dma_cycle(OWN_MY, my_cmd);
      wait_for(OWN_CPU, 1'b0, ok);
      check_eq(64'(ok), 64'(1), "cpu granted after dma");
   endtask

   task automatic sd_test();
      sd_vec_t req;
      req = '0;
      for (int c = 0; c < N_SD_CYCLES; c++) begin
         @(posedge wb_clk);
         for (int k = 0; k < N_SD; k++) begin
            req[k] = req[k] ? ($urandom_range(3, 0) != 0) : ($urandom_range(2, 0) == 0);
         end
         sd_req  <= req;
         sd_mosi <= sd_vec_t'($urandom);
         sd_cs   <= sd_vec_t'($urandom);
      end
      @(posedge wb_clk);
      sd_req <= '0;
   endtask

   //********************
   // test sequence and watchdog
   //********************
   initial begin
      void'($urandom(32'h6bd4_e90f));
      repeat (5) @(posedge wb_clk);
      arst_n_i <= 1'b1;
      @(negedge wb_clk);
      check_eq(64'({cpu_gnt, rk_gnt, my_gnt}), 64'(3'b100), "grants after reset");
      check_eq(64'(sd_gnt), 64'(0), "sd grants after reset");
      for (int i = 0; i < N_RANDOM; i++) cpu_read(wb_addr_t'($urandom));
      for (int i = 0; i < 8; i++) begin
         cpu_read({1'b0, IO_BASES[i][15:0]});    // user mode
         cpu_read({1'b1, IO_BASES[i][15:0]});    // console mode
      end
      dma_test();
      sd_test();
      repeat (3) @(posedge wb_clk);
      $display("checks run: %0d, errors: %0d", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("run timed out, the tests did not finish within %0d ns", WATCHDOG_NS);
      $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- compile.f
mc_bus_pkg.sv
bus_master_arbiter.sv
io_page_decoder.sv
bus_response_merge.sv
sd_card_arbiter.sv
mc_bus_fabric.sv
tb_mc_bus_fabric.sv

//--- Makefile
# Verilator build and run of the bus fabric testbench

VERILATOR ?= verilator
TOP       ?= tb_mc_bus_fabric
FLIST     ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

SRCS := $(shell cat $(FLIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# fails unless the pass message shows up in the output
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf $(OBJ_DIR)
